//--- hdl/exe_defs.svh
`ifndef EXE_DEFS_SVH
`define EXE_DEFS_SVH

// datapath and address width
`define XLEN 32

// register file index width
`define REG_AW 5

// data memory depth in 32-bit words
`define DMEM_WORDS 256

// one quotient bit per step
`define DIV_STEPS 32

`endif

//--- hdl/exe_pkg.sv
`include "exe_defs.svh"

package exe_pkg;

	// operands, results, addresses and word-addressed pc
	typedef logic [`XLEN-1:0] word_t;

	typedef logic [`REG_AW-1:0] reg_addr_t;

	// 0 add, 1 sub, 2 sll, 3 slt, 4 sltu, 5 xor, 6 srl, 7 sra, 8 or, 9 and
	typedef logic [3:0] alu_fn_t;

	// 0 alu, 1 link, 2 mul/div, 3 lui, 4 memory, 5 auipc
	typedef logic [2:0] wb_sel_t;

	// loads 8 lb, 9 lh, 10 lw, 11 lbu, 13 lhu
	// stores 12 sb, 14 sh, 15 sw, 0 is no access
	typedef logic [3:0] mem_op_t;

	// funct3 order of the M extension
	typedef logic [2:0] muldiv_op_t;

	typedef enum logic [1:0]
	{
		div_idle,
		div_run,
		div_done
	} div_state_t;

endpackage

//--- hdl/alu.sv
`timescale 1ns/10ps
`include "exe_defs.svh"

module alu (
	input exe_pkg::alu_fn_t alu_fn,
	input exe_pkg::word_t operand_a,
	input exe_pkg::word_t operand_b,
	input logic btype,
	input logic bneq,
	output exe_pkg::word_t result,
	output logic btaken
);
	import exe_pkg::*;

	logic [$clog2(`XLEN)-1:0] shamt;
	word_t diff;
	logic lt_s;
	logic lt_u;
	logic cmp;

	assign shamt = operand_b[$clog2(`XLEN)-1:0]; // low five bits only
	assign diff = operand_a - operand_b;
	assign lt_s = $signed(operand_a) < $signed(operand_b);
	assign lt_u = operand_a < operand_b;

	always_comb
	begin
		case (alu_fn)
			4'd0: result = operand_a + operand_b;
			4'd1: result = diff;
			4'd2: result = operand_a << shamt;
			4'd3: result = word_t'(lt_s);
			4'd4: result = word_t'(lt_u);
			4'd5: result = operand_a ^ operand_b;
			4'd6: result = operand_a >> shamt;
			4'd7: result = word_t'($signed(operand_a) >>> shamt);
			4'd8: result = operand_a | operand_b;
			4'd9: result = operand_a & operand_b;
			default: result = '0;
		endcase
	end

	// branch compare reuses the subtract and less-than paths
	always_comb
	begin
		case (alu_fn)
			4'd1: cmp = (diff == '0); // beq
			4'd3: cmp = lt_s; // blt
			4'd4: cmp = lt_u; // bltu
			default: cmp = 1'b0;
		endcase
	end

	// bne, bge and bgeu are the inverted forms
	assign btaken = btype & (cmp ^ bneq);

endmodule

//--- hdl/branch_unit.sv
`timescale 1ns/10ps

module branch_unit (
	input exe_pkg::word_t pc,
	input exe_pkg::word_t operand_a,
	input exe_pkg::word_t b_imm,
	input exe_pkg::word_t j_imm,
	input exe_pkg::word_t i_imm,
	input logic btaken,
	input logic j,
	input logic jr,
	output exe_pkg::word_t target
);
	import exe_pkg::*;

	word_t jalr_tgt;
	word_t jal_tgt;
	word_t br_tgt;

	assign jalr_tgt = operand_a + i_imm; // register relative
	assign jal_tgt = pc + j_imm;
	assign br_tgt = btaken ? pc + b_imm : pc + word_t'(1); // not taken falls through

	always_comb
	begin
		if (jr)
			target = jalr_tgt;
		else if (j)
			target = jal_tgt;
		else
			target = br_tgt;
	end

endmodule

//--- hdl/mul_div.sv
`timescale 1ns/10ps
`include "exe_defs.svh"

module mul_div (
	input logic clk,
	input logic nrst,
	input exe_pkg::word_t a,
	input exe_pkg::word_t b,
	input exe_pkg::muldiv_op_t op,
	input logic start,
	output exe_pkg::word_t res,
	output logic busy
);
	import exe_pkg::*;

	localparam int CNT_W = $clog2(`DIV_STEPS);

	logic a_sgn;
	logic b_sgn;
	logic signed [2*`XLEN+1:0] prod;
	word_t mul_res;

	div_state_t state;
	logic [CNT_W-1:0] cnt;
	word_t dvs_r;
	word_t rem_r;
	word_t quo_r;
	logic neg_q;
	logic neg_r;
	logic zero_r;
	logic rem_sel;
	logic [`XLEN:0] rem_sh;
	logic [`XLEN:0] diff;
	word_t q_fix;
	word_t r_fix;
	word_t div_res;

	// mulh and mulhsu treat a as signed, only mulh treats b as signed
	assign a_sgn = (op == 3'd1) || (op == 3'd2);
	assign b_sgn = (op == 3'd1);
	assign prod = $signed({a_sgn & a[`XLEN-1], a}) * $signed({b_sgn & b[`XLEN-1], b});
	assign mul_res = (op == 3'd0) ? prod[`XLEN-1:0] : prod[2*`XLEN-1:`XLEN];

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			state <= div_idle;
			cnt <= '0;
		end
		else
		begin
			case (state)
				div_idle:
					if (start)
					begin
						state <= div_run;
						cnt <= '0;
					end
				div_run:
				begin
					cnt <= cnt + 1'b1;
					if (cnt == CNT_W'(`DIV_STEPS - 1))
						state <= div_done;
				end
				div_done: state <= div_idle; // result held for one cycle
				default: state <= div_idle;
			endcase
		end
	end

	// restoring step on magnitudes
	assign rem_sh = {rem_r, quo_r[`XLEN-1]};
	assign diff = rem_sh - {1'b0, dvs_r};

	always_ff @(posedge clk)
	begin
		if (state == div_idle && start)
		begin
			quo_r <= (!op[0] && a[`XLEN-1]) ? -a : a; // dividend shifts out of quo_r
			dvs_r <= (!op[0] && b[`XLEN-1]) ? -b : b;
			rem_r <= '0;
			neg_q <= !op[0] && (a[`XLEN-1] ^ b[`XLEN-1]);
			neg_r <= !op[0] && a[`XLEN-1]; // remainder takes the dividend sign
			zero_r <= (b == '0);
			rem_sel <= op[1];
		end
		else if (state == div_run)
		begin
			rem_r <= diff[`XLEN] ? rem_sh[`XLEN-1:0] : diff[`XLEN-1:0];
			quo_r <= {quo_r[`XLEN-2:0], ~diff[`XLEN]};
		end
	end

	// overflow needs no special case, the magnitudes already give it
	assign q_fix = zero_r ? '1 : (neg_q ? -quo_r : quo_r);
	assign r_fix = neg_r ? -rem_r : rem_r;
	assign div_res = rem_sel ? r_fix : q_fix;

	assign res = op[2] ? div_res : mul_res;
	assign busy = (state == div_run);

endmodule

//--- hdl/dmem_port.sv
`timescale 1ns/10ps
`include "exe_defs.svh"

module dmem_port (
	input logic clk,
	input logic nrst,
	input exe_pkg::mem_op_t mem_op4,
	input exe_pkg::word_t base,
	input exe_pkg::word_t store_data,
	input exe_pkg::word_t s_imm,
	input exe_pkg::word_t i_imm,
	output exe_pkg::word_t mem_out6,
	output logic addr_misaligned6
);
	import exe_pkg::*;

	localparam int IDX_W = $clog2(`DMEM_WORDS);

	word_t mem [`DMEM_WORDS];
	word_t addr4;
	logic is_load4;
	logic is_store4;
	logic uns4;
	logic [1:0] size4; // 0 byte, 1 half, 2 word
	logic misaligned4;
	logic [3:0] be4;
	word_t wdata4;

	logic load5;
	logic uns5;
	logic misaligned5;
	logic [1:0] size5;
	logic [1:0] off5;
	logic [IDX_W-1:0] idx5;

	logic uns6;
	logic [1:0] size6;
	logic [1:0] off6;
	word_t rdata6;
	word_t shifted6;

	assign is_load4 = mem_op4 inside {4'd8, 4'd9, 4'd10, 4'd11, 4'd13};
	assign is_store4 = mem_op4 inside {4'd12, 4'd14, 4'd15};
	assign uns4 = mem_op4 inside {4'd11, 4'd13};
	assign size4 = (mem_op4 inside {4'd9, 4'd13, 4'd14}) ? 2'd1 :
		(mem_op4 inside {4'd10, 4'd15}) ? 2'd2 : 2'd0;

	assign addr4 = base + (is_store4 ? s_imm : i_imm); // byte address
	assign misaligned4 = (is_load4 | is_store4) &
		((size4 == 2'd1 && addr4[0]) || (size4 == 2'd2 && addr4[1:0] != 2'b00));

	// replicate store data across the lanes
	always_comb
	begin
		case (size4)
			2'd0: wdata4 = {4{store_data[7:0]}};
			2'd1: wdata4 = {2{store_data[15:0]}};
			default: wdata4 = store_data;
		endcase
		case (size4)
			2'd0: be4 = 4'b0001 << addr4[1:0];
			2'd1: be4 = addr4[1] ? 4'b1100 : 4'b0011;
			default: be4 = 4'b1111;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (is_store4 && !misaligned4)
		begin
			for (int i = 0; i < 4; i++)
				if (be4[i])
					mem[addr4[IDX_W+1:2]][8*i +: 8] <= wdata4[8*i +: 8];
		end
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			load5 <= 1'b0;
			uns5 <= 1'b0;
			misaligned5 <= 1'b0;
			size5 <= '0;
			off5 <= '0;
			idx5 <= '0;
			uns6 <= 1'b0;
			size6 <= '0;
			off6 <= '0;
			rdata6 <= '0;
			addr_misaligned6 <= 1'b0;
		end
		else
		begin
			load5 <= is_load4;
			uns5 <= uns4;
			misaligned5 <= misaligned4;
			size5 <= size4;
			off5 <= addr4[1:0];
			idx5 <= addr4[IDX_W+1:2];
			uns6 <= uns5;
			size6 <= size5;
			off6 <= off5;
			if (load5)
				rdata6 <= mem[idx5]; // synchronous read at the pipe-6 edge
			addr_misaligned6 <= misaligned5;
		end
	end

	assign shifted6 = rdata6 >> {off6, 3'b000};

	always_comb
	begin
		case (size6)
			2'd0: mem_out6 = uns6 ? word_t'(shifted6[7:0]) :
				{{(`XLEN-8){shifted6[7]}}, shifted6[7:0]};
			2'd1: mem_out6 = uns6 ? word_t'(shifted6[15:0]) :
				{{(`XLEN-16){shifted6[15]}}, shifted6[15:0]};
			default: mem_out6 = rdata6;
		endcase
	end

endmodule

//--- hdl/exe_stage.sv
`timescale 1ns/10ps

module exe_stage (
	input logic clk,
	input logic nrst,
	input exe_pkg::word_t op_a,
	input exe_pkg::word_t op_b,
	input exe_pkg::word_t pc4,
	input exe_pkg::word_t b_imm4,
	input exe_pkg::word_t j_imm4,
	input exe_pkg::word_t u_imm4,
	input exe_pkg::word_t s_imm4,
	input exe_pkg::reg_addr_t rd4,
	input exe_pkg::wb_sel_t wb_sel4,
	input exe_pkg::alu_fn_t alu_fn4,
	input exe_pkg::mem_op_t mem_op4,
	input exe_pkg::muldiv_op_t muldiv_op4,
	input logic we4,
	input logic btype4,
	input logic bneq4,
	input logic j4,
	input logic jr4,
	input logic muldiv_en4,
	output exe_pkg::word_t wb_data6,
	output exe_pkg::word_t target,
	output exe_pkg::word_t mem_out6,
	output exe_pkg::reg_addr_t rd6,
	output logic we6,
	output logic bjtaken6,
	output logic addr_misaligned6,
	output logic stall
);
	import exe_pkg::*;

	word_t alu_res4;
	logic btaken4;

	word_t a5;
	word_t b5;
	word_t pc5;
	word_t u_imm5;
	word_t alu_res5;
	word_t muldiv_res5;
	reg_addr_t rd5;
	wb_sel_t wb_sel5;
	muldiv_op_t muldiv_op5;
	logic we5;
	logic muldiv_en5;
	logic div_start;
	logic div_busy;
	logic div_issued;

	word_t alu_res6;
	word_t pc6;
	word_t u_imm6;
	word_t auipc6;
	word_t muldiv6;
	wb_sel_t wb_sel6;
	logic we6_r;

	alu u_alu (
		.alu_fn(alu_fn4),
		.operand_a(op_a),
		.operand_b(op_b),
		.btype(btype4),
		.bneq(bneq4),
		.result(alu_res4),
		.btaken(btaken4)
	);

	branch_unit u_bu (
		.pc(pc4),
		.operand_a(op_a),
		.b_imm(b_imm4),
		.j_imm(j_imm4),
		.i_imm(op_b), // jalr offset
		.btaken(btaken4),
		.j(j4),
		.jr(jr4),
		.target(target)
	);

	dmem_port u_dmem (
		.clk(clk),
		.nrst(nrst),
		.mem_op4(mem_op4),
		.base(op_a),
		.store_data(op_b),
		.s_imm(s_imm4),
		.i_imm(op_b), // load offset
		.mem_out6(mem_out6),
		.addr_misaligned6(addr_misaligned6)
	);

	mul_div u_md (
		.clk(clk),
		.nrst(nrst),
		.a(a5),
		.b(b5),
		.op(muldiv_op5),
		.start(div_start),
		.res(muldiv_res5),
		.busy(div_busy)
	);

	assign bjtaken6 = btaken4 | j4 | jr4;

	// start once per divide held in pipe 5
	assign div_start = muldiv_en5 & muldiv_op5[2] & ~div_issued;
	assign stall = div_busy | div_start;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			a5 <= '0;
			b5 <= '0;
			pc5 <= '0;
			u_imm5 <= '0;
			alu_res5 <= '0;
			rd5 <= '0;
			wb_sel5 <= '0;
			muldiv_op5 <= '0;
			we5 <= 1'b0;
			muldiv_en5 <= 1'b0;
			div_issued <= 1'b0;
		end
		else
		begin
			if (div_start)
				div_issued <= 1'b1;
			else if (!stall)
				div_issued <= 1'b0; // divide leaves pipe 5
			if (!stall) // pipe 5 holds through the divide
			begin
				a5 <= op_a;
				b5 <= op_b;
				pc5 <= pc4;
				u_imm5 <= u_imm4;
				alu_res5 <= alu_res4;
				rd5 <= rd4;
				wb_sel5 <= wb_sel4;
				muldiv_op5 <= muldiv_op4;
				we5 <= we4;
				muldiv_en5 <= muldiv_en4;
			end
		end
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			alu_res6 <= '0;
			pc6 <= '0;
			u_imm6 <= '0;
			auipc6 <= '0;
			muldiv6 <= '0;
			rd6 <= '0;
			wb_sel6 <= '0;
			we6_r <= 1'b0;
		end
		else
		begin
			alu_res6 <= alu_res5;
			pc6 <= pc5;
			u_imm6 <= u_imm5;
			auipc6 <= pc5 + u_imm5;
			muldiv6 <= muldiv_res5;
			rd6 <= rd5;
			wb_sel6 <= wb_sel5;
			we6_r <= we5 & ~stall; // bubble while stalled
		end
	end

	assign we6 = we6_r & ~addr_misaligned6;

	always_comb
	begin
		case (wb_sel6)
			3'd0: wb_data6 = alu_res6;
			3'd1: wb_data6 = pc6 + word_t'(1); // link, pc is word addressed
			3'd2: wb_data6 = muldiv6;
			3'd3: wb_data6 = u_imm6;
			3'd4: wb_data6 = mem_out6;
			3'd5: wb_data6 = auipc6;
			default: wb_data6 = '0;
		endcase
	end

endmodule

//--- test/exe_stage_chk.sv
`timescale 1ns/10ps

module exe_stage_chk (
	input logic clk,
	input logic nrst,
	input logic we6,
	input logic stall,
	input logic addr_misaligned6,
	input logic bjtaken6,
	input logic j4,
	input logic jr4,
	input logic btype4
);

	// pipe registers come out of reset cleared
	a_reset_quiet: assert property (@(posedge clk)
		!nrst |=> (!we6 && !stall && !addr_misaligned6))
	else
		$error("control outputs not low after reset");

	// stalled cycle leaves a bubble in pipe 6
	a_stall_bubble: assert property (@(posedge clk) disable iff (!nrst)
		stall |=> !we6)
	else
		$error("we6 high right after a stall cycle");

	a_misaligned_no_we: assert property (@(posedge clk) disable iff (!nrst)
		addr_misaligned6 |-> !we6)
	else
		$error("we6 high on a misaligned access");

	a_taken_needs_ctl: assert property (@(posedge clk) disable iff (!nrst)
		bjtaken6 |-> (j4 || jr4 || btype4))
	else
		$error("bjtaken6 without a branch or jump");

endmodule

bind exe_stage exe_stage_chk chk0 (
	.clk(clk),
	.nrst(nrst),
	.we6(we6),
	.stall(stall),
	.addr_misaligned6(addr_misaligned6),
	.bjtaken6(bjtaken6),
	.j4(j4),
	.jr4(jr4),
	.btype4(btype4)
);

//--- test/exe_stage_tb.sv
`timescale 1ns/10ps
`include "exe_defs.svh"

module exe_stage_tb;
	import exe_pkg::*;

	localparam int N_TESTS = 5;
	localparam int OPS = 64; // upper bound of slots per test
	localparam longint WD_NS = longint'(N_TESTS + 1) * OPS * (`DIV_STEPS + 4) * 8;

	typedef struct packed
	{
		logic vld;
		logic we;
		reg_addr_t rd;
		word_t data;
		logic mis;
		logic ld;
	} exp_t;

	logic clk = 1'b0;
	logic nrst;
	word_t op_a, op_b, pc4, b_imm4, j_imm4, u_imm4, s_imm4;
	reg_addr_t rd4;
	wb_sel_t wb_sel4;
	alu_fn_t alu_fn4;
	mem_op_t mem_op4;
	muldiv_op_t muldiv_op4;
	logic we4, btype4, bneq4, j4, jr4, muldiv_en4;
	word_t wb_data6, target, mem_out6;
	reg_addr_t rd6;
	logic we6, bjtaken6, addr_misaligned6, stall;

	exp_t cur_exp, exp5, exp6;
	logic cur_br, cur_taken;
	word_t cur_tgt;
	word_t seed = 32'ha222;
	word_t shadow [`DMEM_WORDS];
	int checks = 0;
	int errors = 0;
	int last_errors = 0;
	int tests_done = 0;

	exe_stage dut0 (.*);

	always #4 clk = ~clk;

	function automatic word_t rnd();
		seed ^= seed << 13;
		seed ^= seed >> 17;
		seed ^= seed << 5;
		return seed;
	endfunction

	function automatic word_t alu_ref(input alu_fn_t fn, input word_t a, input word_t b);
		case (fn)
			4'd0: return a + b;
			4'd1: return a - b;
			4'd2: return a << b[4:0];
			4'd3: return word_t'($signed(a) < $signed(b));
			4'd4: return word_t'(a < b);
			4'd5: return a ^ b;
			4'd6: return a >> b[4:0];
			4'd7: return word_t'($signed(a) >>> b[4:0]);
			4'd8: return a | b;
			4'd9: return a & b;
			default: return '0;
		endcase
	endfunction

	function automatic word_t muldiv_ref(input muldiv_op_t op, input word_t a, input word_t b);
		logic [63:0] sa;
		logic [63:0] sb;
		logic [63:0] p;
		logic ovf;
		sa = (op == 3'd1 || op == 3'd2) ? {{32{a[31]}}, a} : {32'b0, a};
		sb = (op == 3'd1) ? {{32{b[31]}}, b} : {32'b0, b};
		p = sa * sb; // low 64 bits are exact either way
		ovf = (a == 32'h8000_0000) && (b == '1);
		case (op)
			3'd0: return p[31:0];
			3'd1, 3'd2, 3'd3: return p[63:32];
			3'd4: return (b == '0) ? '1 : ovf ? a : word_t'($signed(a) / $signed(b));
			3'd5: return (b == '0) ? '1 : a / b;
			3'd6: return (b == '0) ? a : ovf ? '0 : word_t'($signed(a) % $signed(b));
			default: return (b == '0) ? a : a % b;
		endcase
	endfunction

	task automatic check_val(input string name, input word_t got, input word_t exp);
		checks++;
		assert (got === exp)
		else
		begin
			$display("ERR %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	// expected values follow the pipe-5 hold and pipe-6 bubble on stall
	always @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			exp5 <= '0;
			exp6 <= '0;
		end
		else
		begin
			if (!stall)
				exp5 <= cur_exp;
			exp6 <= stall ? exp_t'('0) : exp5;
		end
	end

	always @(negedge clk)
	begin
		if (nrst)
		begin
			if (exp6.vld)
			begin
				check_val("we6", word_t'(we6), word_t'(exp6.we));
				check_val("addr_misaligned6", word_t'(addr_misaligned6), word_t'(exp6.mis));
				if (exp6.we)
				begin
					check_val("wb_data6", wb_data6, exp6.data);
					check_val("rd6", word_t'(rd6), word_t'(exp6.rd));
				end
				if (exp6.ld)
					check_val("mem_out6", mem_out6, exp6.data);
			end
			if (cur_br)
				check_val("bjtaken6", word_t'(bjtaken6), word_t'(cur_taken));
			if (cur_taken)
				check_val("target", target, cur_tgt);
		end
	end

	// one issue slot with all inputs cleared to a bubble
	task automatic next_slot();
		@(posedge clk);
		#1;
		{op_a, op_b, pc4, b_imm4, j_imm4, u_imm4, s_imm4} = '0;
		{rd4, wb_sel4, alu_fn4, mem_op4, muldiv_op4} = '0;
		{we4, btype4, bneq4, j4, jr4, muldiv_en4} = '0;
		cur_exp = '0;
		cur_br = 1'b0;
		cur_taken = 1'b0;
		cur_tgt = '0;
	endtask

	task automatic end_test(input string name);
		tests_done++;
		$display("test %s done with %0d errors", name, errors - last_errors);
		last_errors = errors;
	endtask

	task automatic mem_access(input mem_op_t op, input word_t addr, input word_t data);
		word_t off;
		word_t w;
		logic mis;
		next_slot();
		off = rnd() & 32'hff;
		mis = ((op inside {4'd9, 4'd13, 4'd14}) && addr[0]) ||
			((op inside {4'd10, 4'd15}) && addr[1:0] != 2'b00);
		mem_op4 = op;
		op_a = addr - off;
		if (op inside {4'd12, 4'd14, 4'd15}) // store
		begin
			s_imm4 = off;
			op_b = data;
			cur_exp = '{1'b1, 1'b0, '0, '0, mis, 1'b0};
			if (!mis)
			begin
				case (op)
					4'd12: shadow[addr[9:2]][8*addr[1:0] +: 8] = data[7:0];
					4'd14: shadow[addr[9:2]][16*addr[1] +: 16] = data[15:0];
					default: shadow[addr[9:2]] = data;
				endcase
			end
		end
		else
		begin
			op_b = off;
			we4 = 1'b1;
			wb_sel4 = 3'd4;
			rd4 = reg_addr_t'(rnd());
			w = shadow[addr[9:2]] >> (8 * addr[1:0]);
			case (op)
				4'd8: w = {{24{w[7]}}, w[7:0]};
				4'd11: w = {24'b0, w[7:0]};
				4'd9: w = {{16{w[15]}}, w[15:0]};
				4'd13: w = {16'b0, w[15:0]};
				default: w = shadow[addr[9:2]];
			endcase
			cur_exp = '{1'b1, !mis, rd4, w, mis, !mis};
		end
	endtask

	initial
	begin
		word_t base;
		int cnt;
		nrst = 1'b0;
		{op_a, op_b, pc4, b_imm4, j_imm4, u_imm4, s_imm4} = '0;
		{rd4, wb_sel4, alu_fn4, mem_op4, muldiv_op4} = '0;
		{we4, btype4, bneq4, j4, jr4, muldiv_en4} = '0;
		cur_exp = '0;
		cur_br = 1'b0;
		cur_taken = 1'b0;
		cur_tgt = '0;
		repeat (4) @(posedge clk);
		#1 nrst = 1'b1;

		for (int i = 0; i < OPS; i++)
		begin
			next_slot();
			alu_fn4 = alu_fn_t'(rnd() % 10);
			op_a = rnd();
			op_b = rnd();
			rd4 = reg_addr_t'(rnd());
			we4 = rnd() & 1;
			cur_exp = '{1'b1, we4, rd4, alu_ref(alu_fn4, op_a, op_b), 1'b0, 1'b0};
		end
		end_test("alu");

		for (int i = 0; i < 48; i++)
		begin
			next_slot();
			op_a = rnd();
			op_b = ((i / 8) % 2 == 1) ? op_a : rnd(); // equal operands half the time
			pc4 = rnd();
			b_imm4 = rnd();
			j_imm4 = rnd();
			rd4 = reg_addr_t'(rnd());
			cur_br = 1'b1;
			if (i % 8 < 6)
			begin
				btype4 = 1'b1;
				bneq4 = i[0];
				alu_fn4 = (i % 8 < 2) ? 4'd1 : (i % 8 < 4) ? 4'd3 : 4'd4;
				case (alu_fn4)
					4'd1: cur_taken = (op_a == op_b) ^ bneq4;
					4'd3: cur_taken = ($signed(op_a) < $signed(op_b)) ^ bneq4;
					default: cur_taken = (op_a < op_b) ^ bneq4;
				endcase
				cur_tgt = pc4 + b_imm4;
				cur_exp = '{1'b1, 1'b0, '0, '0, 1'b0, 1'b0};
			end
			else
			begin
				j4 = (i % 8 == 6);
				jr4 = (i % 8 == 7);
				we4 = 1'b1;
				wb_sel4 = 3'd1;
				cur_taken = 1'b1;
				cur_tgt = jr4 ? op_a + op_b : pc4 + j_imm4;
				cur_exp = '{1'b1, 1'b1, rd4, pc4 + 1, 1'b0, 1'b0};
			end
		end
		end_test("branch");

		for (int i = 0; i < 32; i++)
		begin
			next_slot();
			pc4 = rnd();
			u_imm4 = rnd() & 32'hffff_f000;
			rd4 = reg_addr_t'(rnd());
			we4 = 1'b1;
			wb_sel4 = i[0] ? 3'd5 : 3'd3;
			cur_exp = '{1'b1, 1'b1, rd4, i[0] ? pc4 + u_imm4 : u_imm4, 1'b0, 1'b0};
		end
		end_test("upper");

		for (int i = 0; i < 4; i++)
		begin
			base = (rnd() % `DMEM_WORDS) << 2;
			mem_access(4'd15, base, rnd());
			mem_access(4'd12, base + (rnd() % 4), rnd());
			mem_access(4'd14, base + 2 * (rnd() % 2), rnd());
			mem_access(4'd10, base, '0);
			mem_access(4'd8, base + (rnd() % 4), '0);
			mem_access(4'd11, base + (rnd() % 4), '0);
			mem_access(4'd9, base + 2 * (rnd() % 2), '0);
			mem_access(4'd13, base + 2 * (rnd() % 2), '0);
			mem_access(4'd14, base + 1, rnd()); // misaligned so nothing is written
			mem_access(4'd15, base + 2, rnd());
			mem_access(4'd9, base + 3, '0);
			mem_access(4'd10, base + 1, '0);
			mem_access(4'd10, base, '0); // contents still intact
		end
		end_test("memory");

		for (int i = 0; i < 28; i++)
		begin
			next_slot();
			muldiv_en4 = 1'b1;
			we4 = 1'b1;
			wb_sel4 = 3'd2;
			rd4 = reg_addr_t'(rnd());
			op_a = rnd();
			op_b = rnd();
			if (i < 16)
				muldiv_op4 = muldiv_op_t'(i % 4);
			else
			begin
				muldiv_op4 = muldiv_op_t'(4 + i % 4);
				if (i >= 20 && i < 24)
					op_b = '0; // divide by zero
				else if (i >= 24)
				begin
					op_a = 32'h8000_0000;
					op_b = '1;
				end
			end
			cur_exp = '{1'b1, 1'b1, rd4, muldiv_ref(muldiv_op4, op_a, op_b),
				1'b0, 1'b0};
			if (muldiv_op4[2])
			begin
				// hold the divide until stall drops
				@(posedge clk);
				#1;
				cnt = 0;
				if (!stall)
				begin
					$display("divide did not raise stall");
					errors++;
				end
				while (stall && cnt <= `DIV_STEPS + 4)
				begin
					@(posedge clk);
					#1;
					cnt++;
				end
				if (stall)
				begin
					$display("divide stall did not end in time");
					errors++;
				end
				cur_exp = '0;
				{we4, muldiv_en4, wb_sel4} = '0;
			end
		end
		repeat (3)
			next_slot(); // drain the pipe
		end_test("muldiv");

		$display("tests %0d checks %0d errors %0d", tests_done, checks, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

	initial
	begin
		#(WD_NS);
		$display("watchdog expired before the tests finished");
		$display(">>> FAIL");
		$finish;
	end

endmodule

//--- all.f
+incdir+hdl
hdl/exe_pkg.sv
hdl/alu.sv
hdl/branch_unit.sv
hdl/mul_div.sv
hdl/dmem_port.sv
hdl/exe_stage.sv
test/exe_stage_chk.sv
test/exe_stage_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the execute stage testbench with Verilator
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module exe_stage_tb -f all.f -Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "compile failed"
	exit 1
fi

./obj_dir/Vexe_stage_tb > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -qx ">>> PASS" sim.log; then
	exit 0
fi
exit 1
